// File: common/fetch_pkg.sv
/*
 * Fetch package
 * Address and instruction widths, instruction cache geometry, reset PC,
 * fetch exception codes and the structs passed between fetch stages
 */
package fetch_pkg;

	// Address and instruction widths
	localparam int XLEN = 32;
	localparam int ILEN = 32;

	// Bytes per instruction, the sequential PC step
	localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;

	// Cache line geometry
	localparam int LINE_WORDS = 4;
	localparam int LINE_LEN = LINE_WORDS * ILEN;
	localparam int OFFSET_LEN = $clog2(LINE_LEN / 8);

	// Direct-mapped i-cache
	localparam int ICACHE_SETS = 8;
	localparam int INDEX_LEN = $clog2(ICACHE_SETS);
	localparam int TAG_LEN = XLEN - INDEX_LEN - OFFSET_LEN;

	// First fetch address out of reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

	// Fetch exceptions, misaligned wins over access fault
	typedef enum logic [1:0] {
		EXC_NONE               = 2'd0,
		EXC_INSTR_MISALIGNED   = 2'd1,
		EXC_INSTR_ACCESS_FAULT = 2'd2
	} except_code_t;

	// PC generator -> i-cache
	typedef struct packed {
		logic [XLEN-1:0] vaddr;
	} pc_req_t;

	// i-cache -> line select, whole line plus its fetch address
	typedef struct packed {
		logic [XLEN-1:0]     vaddr;
		logic [LINE_LEN-1:0] line;
		logic                access_fault;
	} icache_ans_t;

	// Line request to L2, offset bits always zero
	typedef struct packed {
		logic [XLEN-1:0] line_addr;
	} l2_req_t;

	// Refill from L2
	typedef struct packed {
		logic [XLEN-1:0]     line_addr;
		logic [LINE_LEN-1:0] line;
		logic                err;
	} l2_ans_t;

	// Fetched instruction to the consumer
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [ILEN-1:0] instr;
		logic            except_raised;
		except_code_t    except_code;
	} fetch_out_t;

endpackage

// File: hdl/pipe_reg.sv
/*
 * Pipeline transfer register
 * Single-entry valid/ready buffer for any payload type,
 * refills in the cycle its item leaves, flush drops the held item
 */
`timescale 1ns/100ps

module pipe_reg #(
	parameter type T = logic
) (
	input  logic clk_i,
	input  logic reset_i,
	input  logic flush_i,

	// Upstream side
	input  logic in_valid_i,
	input  T     in_data_i,
	output logic in_ready_o,

	// Downstream side
	output logic out_valid_o,
	output T     out_data_o,
	input  logic out_ready_i
);

	logic full_q;
	T     data_q;

	// Room when empty or when the held item leaves now
	assign in_ready_o = !full_q || out_ready_i;

	always_ff @(posedge clk_i) begin
		if (reset_i || flush_i) begin
			full_q <= 1'b0;
		end else if (in_ready_o) begin
			full_q <= in_valid_i;
		end
	end

	// Payload, loaded only on acceptance
	always_ff @(posedge clk_i) begin
		if (in_valid_i && in_ready_o) begin
			data_q <= in_data_i;
		end
	end

	assign out_valid_o = full_q;
	assign out_data_o  = data_q;

endmodule

// File: fetch/pc_gen.sv
/*
 * PC generator
 * Holds the fetch PC and offers it to the i-cache,
 * steps by one instruction on acceptance, redirects on flush
 */
`timescale 1ns/100ps

module pc_gen (
	input  logic                       clk_i,
	input  logic                       reset_i,

	// Redirect from the control unit
	input  logic                       flush_i,
	input  logic [fetch_pkg::XLEN-1:0] flush_pc_i,

	// Request to the i-cache
	output logic                       req_valid_o,
	output fetch_pkg::pc_req_t         req_o,
	input  logic                       req_ready_i
);

	logic [fetch_pkg::XLEN-1:0] pc_q;
	logic                       valid_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc_q    <= fetch_pkg::RESET_PC;
			valid_q <= 1'b0;
		end else begin
			// Always requesting once out of reset
			valid_q <= 1'b1;
			if (flush_i) begin
				// Redirect beats a same-cycle acceptance
				pc_q <= flush_pc_i;
			end else if (valid_q && req_ready_i) begin
				pc_q <= pc_q + fetch_pkg::INSTR_BYTES;
			end
		end
	end

	// No alignment check here, line select flags it
	assign req_valid_o = valid_q;
	assign req_o.vaddr = pc_q;

endmodule

// File: icache/icache.sv
/*
 * Instruction cache
 * Blocking direct-mapped cache, whole-line refill over the L2 port,
 * one miss at a time, flush during a miss drops the answer
 */
`timescale 1ns/100ps

module icache (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  flush_i,

	// Fetch request from the PC stage
	input  logic                  req_valid_i,
	input  fetch_pkg::pc_req_t    req_i,
	output logic                  req_ready_o,

	// Line answer to line select
	output logic                  ans_valid_o,
	output fetch_pkg::icache_ans_t ans_o,
	input  logic                  ans_ready_i,

	// L2 request port
	output logic                  l2_req_valid_o,
	output fetch_pkg::l2_req_t    l2_req_o,
	input  logic                  l2_req_ready_i,

	// L2 answer port, always taken
	input  logic                  l2_ans_valid_i,
	input  fetch_pkg::l2_ans_t    l2_ans_i
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_MISS_REQ,
		S_MISS_WAIT,
		S_ANSWER
	} state_t;

	state_t state_q;

	// Storage, only valid bits are reset
	logic [fetch_pkg::ICACHE_SETS-1:0] line_valid_q;
	logic [fetch_pkg::TAG_LEN-1:0]     tag_q  [fetch_pkg::ICACHE_SETS];
	logic [fetch_pkg::LINE_LEN-1:0]    line_q [fetch_pkg::ICACHE_SETS];

	// Answer register and miss bookkeeping
	logic                       ans_valid_q;
	fetch_pkg::icache_ans_t     ans_q;
	logic [fetch_pkg::XLEN-1:0] miss_addr_q;
	logic                       drop_q;

	// Lookup fields
	logic [fetch_pkg::INDEX_LEN-1:0] req_idx;
	logic [fetch_pkg::TAG_LEN-1:0]   req_tag;
	logic                            hit;
	logic                            lookup;

	// Refill fields, taken from the returned line address
	logic [fetch_pkg::INDEX_LEN-1:0] fill_idx;
	logic [fetch_pkg::TAG_LEN-1:0]   fill_tag;
	logic                            fill;

	assign req_idx = req_i.vaddr[fetch_pkg::OFFSET_LEN +: fetch_pkg::INDEX_LEN];
	assign req_tag = req_i.vaddr[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_LEN];
	assign hit     = line_valid_q[req_idx] && (tag_q[req_idx] == req_tag);

	assign fill_idx = l2_ans_i.line_addr[fetch_pkg::OFFSET_LEN +: fetch_pkg::INDEX_LEN];
	assign fill_tag = l2_ans_i.line_addr[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_LEN];
	assign fill     = (state_q == S_MISS_WAIT) && l2_ans_valid_i;

	// Blocking, new lookups only in idle with the answer slot free
	assign req_ready_o = (state_q == S_IDLE) && (!ans_valid_q || ans_ready_i);
	// Requests seen under flush are stale
	assign lookup      = req_valid_i && req_ready_o && !flush_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q      <= S_IDLE;
			ans_valid_q  <= 1'b0;
			drop_q       <= 1'b0;
			line_valid_q <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (flush_i) begin
						ans_valid_q <= 1'b0;
					end else if (lookup) begin
						ans_valid_q <= hit;
						if (!hit) begin
							state_q <= S_MISS_REQ;
							drop_q  <= 1'b0;
						end
					end else if (ans_ready_i) begin
						ans_valid_q <= 1'b0;
					end
				end
				S_MISS_REQ: begin
					// Request still goes out, answer gets dropped
					drop_q <= drop_q || flush_i;
					if (l2_req_ready_i) begin
						state_q <= S_MISS_WAIT;
					end
				end
				S_MISS_WAIT: begin
					if (l2_ans_valid_i) begin
						// Faulty refill leaves the set untouched
						if (!l2_ans_i.err) begin
							line_valid_q[fill_idx] <= 1'b1;
						end
						if (drop_q || flush_i) begin
							state_q <= S_IDLE;
						end else begin
							ans_valid_q <= 1'b1;
							state_q     <= S_ANSWER;
						end
					end else begin
						drop_q <= drop_q || flush_i;
					end
				end
				S_ANSWER: begin
					if (flush_i || ans_ready_i) begin
						ans_valid_q <= 1'b0;
						state_q     <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// Payload and arrays
	always_ff @(posedge clk_i) begin
		if (lookup) begin
			miss_addr_q <= req_i.vaddr;
			if (hit) begin
				ans_q.vaddr        <= req_i.vaddr;
				ans_q.line         <= line_q[req_idx];
				ans_q.access_fault <= 1'b0;
			end
		end
		if (fill) begin
			ans_q.vaddr        <= miss_addr_q;
			ans_q.line         <= l2_ans_i.line;
			ans_q.access_fault <= l2_ans_i.err;
			if (!l2_ans_i.err) begin
				tag_q[fill_idx]  <= fill_tag;
				line_q[fill_idx] <= l2_ans_i.line;
			end
		end
	end

	assign ans_valid_o = ans_valid_q;
	assign ans_o       = ans_q;

	// Line-aligned request, held stable by the miss address
	assign l2_req_valid_o     = (state_q == S_MISS_REQ);
	assign l2_req_o.line_addr = {miss_addr_q[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_LEN],
		{fetch_pkg::OFFSET_LEN{1'b0}}};

endmodule

// File: fetch/line_select.sv
/*
 * Line select
 * Extracts the addressed instruction from the i-cache line,
 * raises fetch exceptions and registers the result for the consumer
 */
`timescale 1ns/100ps

module line_select (
	input  logic                   clk_i,
	input  logic                   reset_i,
	input  logic                   flush_i,

	// Answer from the i-cache
	input  logic                   ans_valid_i,
	input  fetch_pkg::icache_ans_t ans_i,
	output logic                   ans_ready_o,

	// Fetch output to the consumer
	output logic                   fetch_valid_o,
	output fetch_pkg::fetch_out_t  fetch_out_o,
	input  logic                   fetch_ready_i
);

	logic                  valid_q;
	fetch_pkg::fetch_out_t out_q;
	fetch_pkg::fetch_out_t out_d;

	logic [fetch_pkg::OFFSET_LEN-3:0] word_idx;
	logic                             misaligned;
	logic                             accept;

	// Word inside the line
	assign word_idx   = ans_i.vaddr[fetch_pkg::OFFSET_LEN-1:2];
	assign misaligned = (ans_i.vaddr[1:0] != 2'b00);

	assign ans_ready_o = !valid_q || fetch_ready_i;
	assign accept      = ans_valid_i && ans_ready_o && !flush_i;

	always_comb begin
		out_d.pc            = ans_i.vaddr;
		out_d.instr         = ans_i.line[word_idx * fetch_pkg::ILEN +: fetch_pkg::ILEN];
		out_d.except_raised = 1'b0;
		out_d.except_code   = fetch_pkg::EXC_NONE;
		// Misaligned first, then access fault
		if (misaligned) begin
			out_d.except_raised = 1'b1;
			out_d.except_code   = fetch_pkg::EXC_INSTR_MISALIGNED;
		end else if (ans_i.access_fault) begin
			out_d.except_raised = 1'b1;
			out_d.except_code   = fetch_pkg::EXC_INSTR_ACCESS_FAULT;
		end
		// No instruction bits on an exception
		if (out_d.except_raised) begin
			out_d.instr = '0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i || flush_i) begin
			valid_q <= 1'b0;
		end else if (ans_ready_o) begin
			valid_q <= ans_valid_i;
		end
	end

	// Held while the consumer stalls
	always_ff @(posedge clk_i) begin
		if (accept) begin
			out_q <= out_d;
		end
	end

	assign fetch_valid_o = valid_q;
	assign fetch_out_o   = out_q;

endmodule

// File: hdl/datapath_memory.sv
/*
 * Instruction-side front end top level
 * PC generator, transfer register, i-cache and line select in a chain,
 * with the L2 port and the consumer port brought out
 */
`timescale 1ns/100ps

module datapath_memory (
	input  logic                       clk_i,
	input  logic                       reset_i,

	// Control unit redirect
	input  logic                       flush_i,
	input  logic [fetch_pkg::XLEN-1:0] flush_pc_i,

	// Consumer
	output logic                       fetch_valid_o,
	output fetch_pkg::fetch_out_t      fetch_out_o,
	input  logic                       fetch_ready_i,

	// L2 request
	output logic                       l2_req_valid_o,
	output fetch_pkg::l2_req_t         l2_req_o,
	input  logic                       l2_req_ready_i,

	// L2 answer
	input  logic                       l2_ans_valid_i,
	input  fetch_pkg::l2_ans_t         l2_ans_i
);

	// PC stage -> transfer register
	logic                   pc_valid;
	fetch_pkg::pc_req_t     pc_req;
	logic                   pc_ready;

	// Transfer register -> i-cache
	logic                   ic_req_valid;
	fetch_pkg::pc_req_t     ic_req;
	logic                   ic_req_ready;

	// i-cache -> line select
	logic                   ic_ans_valid;
	fetch_pkg::icache_ans_t ic_ans;
	logic                   ic_ans_ready;

	pc_gen u_pc_gen (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.flush_i    (flush_i),
		.flush_pc_i (flush_pc_i),
		.req_valid_o(pc_valid),
		.req_o      (pc_req),
		.req_ready_i(pc_ready)
	);

	pipe_reg #(
		.T(fetch_pkg::pc_req_t)
	) u_pc_reg (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.flush_i    (flush_i),
		.in_valid_i (pc_valid),
		.in_data_i  (pc_req),
		.in_ready_o (pc_ready),
		.out_valid_o(ic_req_valid),
		.out_data_o (ic_req),
		.out_ready_i(ic_req_ready)
	);

	icache u_icache (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.flush_i       (flush_i),
		.req_valid_i   (ic_req_valid),
		.req_i         (ic_req),
		.req_ready_o   (ic_req_ready),
		.ans_valid_o   (ic_ans_valid),
		.ans_o         (ic_ans),
		.ans_ready_i   (ic_ans_ready),
		.l2_req_valid_o(l2_req_valid_o),
		.l2_req_o      (l2_req_o),
		.l2_req_ready_i(l2_req_ready_i),
		.l2_ans_valid_i(l2_ans_valid_i),
		.l2_ans_i      (l2_ans_i)
	);

	line_select u_line_select (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.flush_i      (flush_i),
		.ans_valid_i  (ic_ans_valid),
		.ans_i        (ic_ans),
		.ans_ready_o  (ic_ans_ready),
		.fetch_valid_o(fetch_valid_o),
		.fetch_out_o  (fetch_out_o),
		.fetch_ready_i(fetch_ready_i)
	);

endmodule

// File: tb/tb_clock.sv
/*
 * Testbench clock
 * Free-running clock with a 4 ns period
 */
`timescale 1ns/100ps

module tb_clock (
	output logic clk_o
);

	// Half period in ns
	localparam real HALF_PERIOD = 2.0;

	initial begin
		clk_o = 1'b0;
		forever begin
			#(HALF_PERIOD) clk_o = ~clk_o;
		end
	end

endmodule

// File: tb/datapath_memory_checker.sv
/*
 * Front end protocol checker
 * Stall stability on the consumer and L2 ports, flush clearing
 * the output, and a single outstanding refill
 */
`timescale 1ns/100ps

module datapath_memory_checker (
	input logic                  clk_i,
	input logic                  reset_i,
	input logic                  flush_i,
	input logic                  fetch_valid_o,
	input fetch_pkg::fetch_out_t fetch_out_o,
	input logic                  fetch_ready_i,
	input logic                  l2_req_valid_o,
	input fetch_pkg::l2_req_t    l2_req_o,
	input logic                  l2_req_ready_i,
	input logic                  l2_ans_valid_i
);

	// Refill requested and not yet answered
	logic refill_pending;
	// Count of failed assertions
	int   assert_fails = 0;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			refill_pending <= 1'b0;
		end else if (l2_req_valid_o && l2_req_ready_i) begin
			refill_pending <= 1'b1;
		end else if (l2_ans_valid_i) begin
			refill_pending <= 1'b0;
		end
	end

	// Consumer output frozen while stalled
	fetch_stable: assert property (@(posedge clk_i) disable iff (reset_i)
		fetch_valid_o && !fetch_ready_i && !flush_i |=> fetch_valid_o && $stable(fetch_out_o))
		else begin
			$error("fetch output changed while stalled");
			assert_fails++;
		end

	// L2 request frozen while stalled
	l2_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
		l2_req_valid_o && !l2_req_ready_i |=> l2_req_valid_o && $stable(l2_req_o))
		else begin
			$error("L2 request changed while stalled");
			assert_fails++;
		end

	flush_clears_output: assert property (@(posedge clk_i) disable iff (reset_i)
		flush_i |=> !fetch_valid_o)
		else begin
			$error("fetch valid high after flush");
			assert_fails++;
		end

	// Blocking cache, one miss at a time
	single_refill: assert property (@(posedge clk_i) disable iff (reset_i)
		refill_pending |-> !l2_req_valid_o)
		else begin
			$error("L2 request during an outstanding refill");
			assert_fails++;
		end

endmodule

// File: tb/datapath_memory_tb.sv
/*
 * Front end testbench
 * Emulates L2, drives redirects and back-pressure, and compares every
 * fetch with a reference model of the fetch rules
 */
`timescale 1ns/100ps

module datapath_memory_tb;

	// Line addresses at or above this answer with err
	localparam logic [31:0] FAULT_BASE = 32'h0000_8000;
	localparam int TIMEOUT_CYCLES = 400 * 40;

	logic                       clk_i;
	logic                       reset_i;
	logic                       flush_i;
	logic [fetch_pkg::XLEN-1:0] flush_pc_i;
	logic                       fetch_valid_o;
	fetch_pkg::fetch_out_t      fetch_out_o;
	logic                       fetch_ready_i;
	logic                       l2_req_valid_o;
	fetch_pkg::l2_req_t         l2_req_o;
	logic                       l2_req_ready_i;
	logic                       l2_ans_valid_i;
	fetch_pkg::l2_ans_t         l2_ans_i;

	// Random state, one process draws from it
	integer seed = 8;
	int     r;
	int     w;

	// L2 emulator state
	logic        l2_busy;
	int          l2_delay;
	logic [31:0] l2_addr;
	logic        req_taken;
	logic        rand_ready;

	// Scoreboard state
	logic [31:0] cursor;
	int          fetched;
	int          cycles;
	logic        window_on;
	int          window_reqs;
	int          fault_line_reqs;
	int          f0;

	tb_clock u_clock (.clk_o(clk_i));

	datapath_memory datapath_memory_i (.*);

	bind datapath_memory datapath_memory_checker u_checker (
		.clk_i(clk_i), .reset_i(reset_i), .flush_i(flush_i),
		.fetch_valid_o(fetch_valid_o), .fetch_out_o(fetch_out_o),
		.fetch_ready_i(fetch_ready_i), .l2_req_valid_o(l2_req_valid_o),
		.l2_req_o(l2_req_o), .l2_req_ready_i(l2_req_ready_i),
		.l2_ans_valid_i(l2_ans_valid_i)
	);

	// Memory content, a mix of the whole word address
	function automatic logic [31:0] word_hash(input logic [31:0] a);
		return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
	endfunction

	// Reference fetch result for one PC
	function automatic fetch_pkg::fetch_out_t expected_fetch(input logic [31:0] pc);
		fetch_pkg::fetch_out_t f;
		f.pc            = pc;
		f.instr         = word_hash({pc[31:2], 2'b00});
		f.except_raised = 1'b0;
		f.except_code   = fetch_pkg::EXC_NONE;
		if (pc[1:0] != 2'b00) begin
			f.except_raised = 1'b1;
			f.except_code   = fetch_pkg::EXC_INSTR_MISALIGNED;
			f.instr         = '0;
		end else if ({pc[31:4], 4'h0} >= FAULT_BASE) begin
			f.except_raised = 1'b1;
			f.except_code   = fetch_pkg::EXC_INSTR_ACCESS_FAULT;
			f.instr         = '0;
		end
		return f;
	endfunction

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_fetch(input fetch_pkg::fetch_out_t got, input fetch_pkg::fetch_out_t exp);
		if (got.pc !== exp.pc)
			report_fail($sformatf("Mismatch fetch_out_o.pc got %h exp %h", got.pc, exp.pc));
		if (got.instr !== exp.instr)
			report_fail($sformatf("Mismatch fetch_out_o.instr got %h exp %h",
				got.instr, exp.instr));
		if (got.except_raised !== exp.except_raised)
			report_fail($sformatf("Mismatch fetch_out_o.except_raised got %h exp %h",
				got.except_raised, exp.except_raised));
		if (got.except_code !== exp.except_code)
			report_fail($sformatf("Mismatch fetch_out_o.except_code got %h exp %h",
				got.except_code, exp.except_code));
	endtask

	// Alignment and miss bookkeeping per accepted request
	task automatic check_l2_req(input fetch_pkg::l2_req_t req);
		if (req.line_addr[3:0] !== 4'h0)
			report_fail($sformatf("Mismatch l2_req_o.line_addr got %h exp %h",
				req.line_addr, {req.line_addr[31:4], 4'h0}));
		if (window_on && req.line_addr >= 32'h1030 && req.line_addr < 32'h1080)
			window_reqs = window_reqs + 1;
		if (req.line_addr == FAULT_BASE)
			fault_line_reqs = fault_line_reqs + 1;
	endtask

	// L2 emulator and random back-pressure
	always @(posedge clk_i) begin
		req_taken = l2_req_valid_o && l2_req_ready_i && !reset_i;
		if (req_taken) begin
			check_l2_req(l2_req_o);
			l2_addr = l2_req_o.line_addr;
		end
		#1;
		l2_ans_valid_i = 1'b0;
		if (l2_busy) begin
			if (l2_delay == 0) begin
				l2_ans_valid_i     = 1'b1;
				l2_ans_i.line_addr = l2_addr;
				l2_ans_i.err       = (l2_addr >= FAULT_BASE);
				for (w = 0; w < fetch_pkg::LINE_WORDS; w++) begin
					l2_ans_i.line[w*32 +: 32] = word_hash(l2_addr + 32'(w * 4));
				end
				l2_busy = 1'b0;
			end else begin
				l2_delay = l2_delay - 1;
			end
		end
		if (req_taken) begin
			l2_busy  = 1'b1;
			// Answer 2 to 9 cycles later
			l2_delay = 1 + ({$random(seed)} % 8);
		end
		r = $random(seed);
		l2_req_ready_i = r[0];
		r = $random(seed);
		fetch_ready_i = rand_ready ? r[0] : 1'b1;
	end

	// Compare process, cursor restarts at each redirect
	always @(posedge clk_i) begin
		if (reset_i) begin
			cursor = fetch_pkg::RESET_PC;
		end else begin
			if (fetch_valid_o && fetch_ready_i) begin
				check_fetch(fetch_out_o, expected_fetch(cursor));
				cursor  = cursor + 32'd4;
				fetched = fetched + 1;
			end
			if (flush_i) begin
				cursor = flush_pc_i;
			end
		end
	end

	// Run limit and protocol assertion watch
	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (datapath_memory_i.u_checker.assert_fails != 0)
			report_fail("A protocol assertion failed in the checker");
		if (cycles >= TIMEOUT_CYCLES)
			report_fail("Timeout: fetches stopped arriving before the end of the test");
	end

	task automatic wait_fetches(input int n);
		int target;
		target = fetched + n;
		while (fetched < target) begin
			@(negedge clk_i);
		end
	endtask

	// One-cycle flush with a new target
	task automatic redirect(input logic [31:0] pc);
		@(posedge clk_i);
		#1;
		flush_i    = 1'b1;
		flush_pc_i = pc;
		@(posedge clk_i);
		#1;
		flush_i = 1'b0;
	endtask

	initial begin
		reset_i = 1'b1;
		flush_i = 1'b0;
		flush_pc_i = '0;
		fetch_ready_i = 1'b0;
		l2_req_ready_i = 1'b0;
		l2_ans_valid_i = 1'b0;
		l2_ans_i = '0;
		l2_busy = 1'b0;
		l2_delay = 0;
		l2_addr = '0;
		rand_ready = 1'b0;
		fetched = 0;
		cycles = 0;
		window_on = 1'b0;
		window_reqs = 0;
		fault_line_reqs = 0;
		repeat (4) @(posedge clk_i);
		#1;
		reset_i = 1'b0;

		// Sequential fetch from reset
		wait_fetches(40);

		// Sets 3 to 7 still hold 0x1030..0x107f
		window_on = 1'b1;
		redirect(32'h0000_1030);
		wait_fetches(20);
		if (window_reqs != 0)
			report_fail("A resident line was fetched again from L2 after a redirect");
		window_on = 1'b0;

		// Random stalls on both ports
		rand_ready = 1'b1;
		redirect(32'h0000_2000);
		wait_fetches(60);

		// Redirect while the cold miss of 0x3000 is pending
		redirect(32'h0000_3000);
		while (!(l2_req_valid_o && l2_req_o.line_addr == 32'h0000_3000)) begin
			@(negedge clk_i);
		end
		redirect(32'h0000_1040);
		wait_fetches(12);

		// Back-to-back redirects
		redirect(32'h0000_5000);
		wait_fetches(5);
		redirect(32'h0000_1008);
		wait_fetches(5);
		redirect(32'h0000_2100);
		wait_fetches(5);

		// Misaligned target
		redirect(32'h0000_1042);
		wait_fetches(8);

		// Faulting line is never installed
		redirect(FAULT_BASE);
		wait_fetches(6);
		f0 = fault_line_reqs;
		redirect(FAULT_BASE);
		wait_fetches(2);
		if (fault_line_reqs <= f0)
			report_fail("A faulting line was served without a new L2 request");

		repeat (10) @(posedge clk_i);
		#1;
		if (datapath_memory_i.u_checker.assert_fails != 0) begin
			report_fail("A protocol assertion failed in the checker");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// File: datapath_memory.f
common/fetch_pkg.sv
hdl/pipe_reg.sv
fetch/pc_gen.sv
icache/icache.sv
fetch/line_select.sv
hdl/datapath_memory.sv
tb/tb_clock.sv
tb/datapath_memory_checker.sv
tb/datapath_memory_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = datapath_memory_tb
FILELIST  = datapath_memory.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then exit 1; fi
	@grep -q "all tests passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
